// File: gpio_config.svh
////////////////////////////////////////////////////////////
// GPIO configuration
// Pin count, bus address width and register word offsets
////////////////////////////////////////////////////////////

`ifndef GPIO_CONFIG_SVH
`define GPIO_CONFIG_SVH

// Number of general-purpose pins
`define GPIO_IOS 32

// Wishbone byte address width, bits 4:2 pick the register
`define GPIO_AW 5

// Word offsets of the register file
`define GPIO_OFS_IN    3'd0
`define GPIO_OFS_OUT   3'd1
`define GPIO_OFS_OE    3'd2
`define GPIO_OFS_INTE  3'd3
`define GPIO_OFS_PTRIG 3'd4
`define GPIO_OFS_CTRL  3'd5
`define GPIO_OFS_INTS  3'd6
// Unused slot, any access ends in a bus error
`define GPIO_OFS_NONE  3'd7

`endif

// File: gpio_pkg.sv
////////////////////////////////////////////////////////////
// GPIO shared types
// Register selects, the pin word and byte-lane helpers
////////////////////////////////////////////////////////////

`default_nettype none
`include "gpio_config.svh"

package gpio_pkg;

  // One register or pin word
  typedef logic [`GPIO_IOS-1:0] gpio_word_t;

  // Register select, value equals the word offset
  typedef enum logic [2:0] {
    REG_IN    = `GPIO_OFS_IN,
    REG_OUT   = `GPIO_OFS_OUT,
    REG_OE    = `GPIO_OFS_OE,
    REG_INTE  = `GPIO_OFS_INTE,
    REG_PTRIG = `GPIO_OFS_PTRIG,
    REG_CTRL  = `GPIO_OFS_CTRL,
    REG_INTS  = `GPIO_OFS_INTS,
    REG_NONE  = `GPIO_OFS_NONE
  } gpio_reg_e;

  // Expand wb_sel byte enables into a bit mask
  function automatic gpio_word_t lane_mask(input logic [3:0] sel);
    gpio_word_t m;
    m = '0;
    for (int i = 0; i < 4; i++) begin
      m[8*i +: 8] = {8{sel[i]}};
    end
    return m;
  endfunction

  // Replace only the enabled byte lanes of a register
  function automatic gpio_word_t lane_write(input gpio_word_t old,
                                            input gpio_word_t dat,
                                            input logic [3:0] sel);
    gpio_word_t m;
    m = lane_mask(sel);
    return (old & ~m) | (dat & m);
  endfunction

endpackage

`default_nettype wire

// File: gpio_wb_ctrl.sv
////////////////////////////////////////////////////////////
// Wishbone classic slave control for the GPIO block
// Address decode, registered ack/err, write strobes, read mux
////////////////////////////////////////////////////////////

`default_nettype none
`include "gpio_config.svh"

module gpio_wb_ctrl (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  // Wishbone slave side
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [`GPIO_AW-1:0]  wb_adr_i,
  input  logic [3:0]           wb_sel_i,
  input  gpio_pkg::gpio_word_t wb_dat_i,
  output gpio_pkg::gpio_word_t wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 wb_err_o,
  // Register values for the read mux
  input  gpio_pkg::gpio_word_t in_sync_i,
  input  gpio_pkg::gpio_word_t out_i,
  input  gpio_pkg::gpio_word_t oe_i,
  input  gpio_pkg::gpio_word_t inte_i,
  input  gpio_pkg::gpio_word_t ptrig_i,
  input  gpio_pkg::gpio_word_t ctrl_i,
  input  gpio_pkg::gpio_word_t ints_i,
  // Write port towards the datapath
  output logic                 wr_stb_o,
  output gpio_pkg::gpio_reg_e  wr_reg_o,
  output logic [3:0]           wr_sel_o,
  output gpio_pkg::gpio_word_t wr_dat_o
);

  logic                 req;
  logic                 acc;
  logic                 bad;
  gpio_pkg::gpio_reg_e  reg_sel;
  gpio_pkg::gpio_word_t rd_val;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  // Request seen by the slave
  assign req = wb_cyc_i & wb_stb_i;
  // Accept only while no termination is pending
  assign acc = req & ~wb_ack_o & ~wb_err_o;

  // Word offset lives in address bits 4:2
  assign reg_sel = gpio_pkg::gpio_reg_e'(wb_adr_i[`GPIO_AW-1:2]);

  // Unused slot, or a write to the read-only input register
  assign bad = (reg_sel == gpio_pkg::REG_NONE) |
               (wb_we_i & (reg_sel == gpio_pkg::REG_IN));

  ////////////////////////////////////////////////////////////
  // Termination
  ////////////////////////////////////////////////////////////

  // Exactly one of ack/err, one cycle after the accepting edge
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      wb_ack_o <= acc & ~bad;
      wb_err_o <= acc & bad;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (reg_sel)
      gpio_pkg::REG_IN:    rd_val = in_sync_i;
      gpio_pkg::REG_OUT:   rd_val = out_i;
      gpio_pkg::REG_OE:    rd_val = oe_i;
      gpio_pkg::REG_INTE:  rd_val = inte_i;
      gpio_pkg::REG_PTRIG: rd_val = ptrig_i;
      gpio_pkg::REG_CTRL:  rd_val = ctrl_i;
      gpio_pkg::REG_INTS:  rd_val = ints_i;
      default:             rd_val = '0;
    endcase
  end

  // Data word presented together with the termination
  always_ff @(posedge wb_clk_i) begin
    if (acc) begin
      wb_dat_o <= bad ? '0 : rd_val;
    end
  end

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////

  // Strobe for the accepting edge, legal writes only
  assign wr_stb_o = acc & wb_we_i & ~bad;
  // Idle select when no write is in flight
  assign wr_reg_o = wr_stb_o ? reg_sel : gpio_pkg::REG_NONE;
  assign wr_sel_o = wb_sel_i;
  assign wr_dat_o = wb_dat_i;

endmodule

`default_nettype wire

// File: gpio_in_sync.sv
////////////////////////////////////////////////////////////
// GPIO input synchronizer
// Two flop stages per pin plus one older copy for edges
////////////////////////////////////////////////////////////

`default_nettype none

module gpio_in_sync (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  // Asynchronous pin inputs
  input  gpio_pkg::gpio_word_t gpio_i,
  // Synchronized value and its one-cycle-older copy
  output gpio_pkg::gpio_word_t in_sync_o,
  output gpio_pkg::gpio_word_t in_prev_o
);

  // First stage, may go metastable
  gpio_pkg::gpio_word_t meta_q;

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      meta_q    <= '0;
      in_sync_o <= '0;
      in_prev_o <= '0;
    end else begin
      meta_q    <= gpio_i;
      // Second stage settles the value
      in_sync_o <= meta_q;
      // Previous value for the edge detector
      in_prev_o <= in_sync_o;
    end
  end

endmodule

`default_nettype wire

// File: gpio_out_regs.sv
////////////////////////////////////////////////////////////
// GPIO output and output-enable registers
// Byte-lane writable, drive the pins and the read mux
////////////////////////////////////////////////////////////

`default_nettype none

module gpio_out_regs (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  // Write port from the bus control
  input  logic                 wr_stb_i,
  input  gpio_pkg::gpio_reg_e  wr_reg_i,
  input  logic [3:0]           wr_sel_i,
  input  gpio_pkg::gpio_word_t wr_dat_i,
  // RGPIO_OUT and RGPIO_OE
  output gpio_pkg::gpio_word_t out_o,
  output gpio_pkg::gpio_word_t oe_o
);

  logic wr_out;
  logic wr_oe;

  // Per-register write enables
  assign wr_out = wr_stb_i & (wr_reg_i == gpio_pkg::REG_OUT);
  assign wr_oe  = wr_stb_i & (wr_reg_i == gpio_pkg::REG_OE);

  ////////////////////////////////////////////////////////////
  // Output values
  ////////////////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      out_o <= '0;
    end else if (wr_out) begin
      out_o <= gpio_pkg::lane_write(out_o, wr_dat_i, wr_sel_i);
    end
  end

  ////////////////////////////////////////////////////////////
  // Output enables
  ////////////////////////////////////////////////////////////

  // Active high, all pins start as inputs
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      oe_o <= '0;
    end else if (wr_oe) begin
      oe_o <= gpio_pkg::lane_write(oe_o, wr_dat_i, wr_sel_i);
    end
  end

endmodule

`default_nettype wire

// File: gpio_int_unit.sv
////////////////////////////////////////////////////////////
// GPIO interrupt unit
// Enable, trigger, control and status registers, edge detect
////////////////////////////////////////////////////////////

`default_nettype none
`include "gpio_config.svh"

module gpio_int_unit (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  // Write port from the bus control
  input  logic                 wr_stb_i,
  input  gpio_pkg::gpio_reg_e  wr_reg_i,
  input  logic [3:0]           wr_sel_i,
  input  gpio_pkg::gpio_word_t wr_dat_i,
  // Synchronized pins and their previous value
  input  gpio_pkg::gpio_word_t in_sync_i,
  input  gpio_pkg::gpio_word_t in_prev_i,
  // Register values for the read mux
  output gpio_pkg::gpio_word_t inte_o,
  output gpio_pkg::gpio_word_t ptrig_o,
  output gpio_pkg::gpio_word_t ctrl_o,
  output gpio_pkg::gpio_word_t ints_o,
  // Interrupt request
  output logic                 inta_o
);

  logic                 ctrl_ie;
  gpio_pkg::gpio_word_t rise;
  gpio_pkg::gpio_word_t fall;
  gpio_pkg::gpio_word_t hit;
  gpio_pkg::gpio_word_t clr;

  ////////////////////////////////////////////////////////////
  // Edge detection
  ////////////////////////////////////////////////////////////

  assign rise = in_sync_i & ~in_prev_i;
  assign fall = ~in_sync_i & in_prev_i;
  // PTRIG picks rising (1) or falling (0), INTE masks the pin
  assign hit  = inte_o & ((ptrig_o & rise) | (~ptrig_o & fall));

  // Write-one-to-clear mask, enabled lanes only
  assign clr = (wr_stb_i && wr_reg_i == gpio_pkg::REG_INTS) ?
               (wr_dat_i & gpio_pkg::lane_mask(wr_sel_i)) : '0;

  // Only the global enable bit exists in RGPIO_CTRL
  assign ctrl_o = {{(`GPIO_IOS-1){1'b0}}, ctrl_ie};

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      inte_o  <= '0;
      ptrig_o <= '0;
      ctrl_ie <= 1'b0;
      ints_o  <= '0;
      inta_o  <= 1'b0;
    end else begin
      if (wr_stb_i && wr_reg_i == gpio_pkg::REG_INTE) begin
        inte_o <= gpio_pkg::lane_write(inte_o, wr_dat_i, wr_sel_i);
      end
      if (wr_stb_i && wr_reg_i == gpio_pkg::REG_PTRIG) begin
        ptrig_o <= gpio_pkg::lane_write(ptrig_o, wr_dat_i, wr_sel_i);
      end
      if (wr_stb_i && wr_reg_i == gpio_pkg::REG_CTRL && wr_sel_i[0]) begin
        ctrl_ie <= wr_dat_i[0];
      end
      // A new edge beats a clear of the same bit
      ints_o <= (ints_o & ~clr) | hit;
      // Request follows the status one edge later
      inta_o <= ctrl_ie & (|ints_o);
    end
  end

endmodule

`default_nettype wire

// File: gpio_top.sv
////////////////////////////////////////////////////////////
// Wishbone GPIO controller, 32 pins
// Connects bus control, input sync, outputs and interrupts
////////////////////////////////////////////////////////////

`default_nettype none
`include "gpio_config.svh"

module gpio_top (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  // Wishbone classic slave
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [`GPIO_AW-1:0]  wb_adr_i,
  input  logic [3:0]           wb_sel_i,
  input  gpio_pkg::gpio_word_t wb_dat_i,
  output gpio_pkg::gpio_word_t wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 wb_err_o,
  output logic                 wb_inta_o,
  // Pins, kept as separate in, out and enable vectors
  input  gpio_pkg::gpio_word_t gpio_i,
  output gpio_pkg::gpio_word_t gpio_o,
  output gpio_pkg::gpio_word_t gpio_oe_o
);

  // Synchronized inputs
  gpio_pkg::gpio_word_t in_sync;
  gpio_pkg::gpio_word_t in_prev;
  // Interrupt registers
  gpio_pkg::gpio_word_t inte;
  gpio_pkg::gpio_word_t ptrig;
  gpio_pkg::gpio_word_t ctrl;
  gpio_pkg::gpio_word_t ints;
  // Write port
  logic                 wr_stb;
  gpio_pkg::gpio_reg_e  wr_reg;
  logic [3:0]           wr_sel;
  gpio_pkg::gpio_word_t wr_dat;

  ////////////////////////////////////////////////////////////
  // Bus control
  ////////////////////////////////////////////////////////////

  gpio_wb_ctrl u_ctrl (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_sel_i  (wb_sel_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .wb_err_o  (wb_err_o),
    .in_sync_i (in_sync),
    .out_i     (gpio_o),
    .oe_i      (gpio_oe_o),
    .inte_i    (inte),
    .ptrig_i   (ptrig),
    .ctrl_i    (ctrl),
    .ints_i    (ints),
    .wr_stb_o  (wr_stb),
    .wr_reg_o  (wr_reg),
    .wr_sel_o  (wr_sel),
    .wr_dat_o  (wr_dat)
  );

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  gpio_in_sync u_in_sync (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .gpio_i    (gpio_i),
    .in_sync_o (in_sync),
    .in_prev_o (in_prev)
  );

  // Output registers drive the pins directly
  gpio_out_regs u_out_regs (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wr_stb_i (wr_stb),
    .wr_reg_i (wr_reg),
    .wr_sel_i (wr_sel),
    .wr_dat_i (wr_dat),
    .out_o    (gpio_o),
    .oe_o     (gpio_oe_o)
  );

  gpio_int_unit u_int_unit (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wr_stb_i  (wr_stb),
    .wr_reg_i  (wr_reg),
    .wr_sel_i  (wr_sel),
    .wr_dat_i  (wr_dat),
    .in_sync_i (in_sync),
    .in_prev_i (in_prev),
    .inte_o    (inte),
    .ptrig_o   (ptrig),
    .ctrl_o    (ctrl),
    .ints_o    (ints),
    .inta_o    (wb_inta_o)
  );

endmodule

`default_nettype wire

// File: gpio_sva.sv
////////////////////////////////////////////////////////////
// Wishbone handshake and reset assertions for the GPIO top
////////////////////////////////////////////////////////////

`default_nettype none

module gpio_sva (
  input logic wb_clk_i,
  input logic wb_rst_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_o,
  input logic wb_err_o,
  input logic wb_inta_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Only one kind of termination at a time
  a_one_term: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wb_ack_o && wb_err_o))
    else $error("ack and err high together");

  // Single-cycle termination
  a_short_term: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (wb_ack_o || wb_err_o) |=> !(wb_ack_o || wb_err_o))
    else $error("termination held for two cycles");

  // A termination always answers a request of the cycle before
  a_after_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (wb_ack_o || wb_err_o) |-> $past(wb_cyc_i && wb_stb_i))
    else $error("termination without a request");

  // Interrupt line quiet in reset
  a_inta_rst: assert property (@(posedge wb_clk_i) wb_rst_i |-> !wb_inta_o)
    else $error("interrupt raised during reset");

endmodule

bind gpio_top gpio_sva u_sva (
  .wb_clk_i  (wb_clk_i),
  .wb_rst_i  (wb_rst_i),
  .wb_cyc_i  (wb_cyc_i),
  .wb_stb_i  (wb_stb_i),
  .wb_ack_o  (wb_ack_o),
  .wb_err_o  (wb_err_o),
  .wb_inta_o (wb_inta_o)
);

`default_nettype wire

// File: gpio_tb.sv
////////////////////////////////////////////////////////////
// GPIO controller testbench
// Random Wishbone traffic against a register model
////////////////////////////////////////////////////////////

`default_nettype none
`include "gpio_config.svh"

module gpio_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                 wb_clk_i;
  logic                 wb_rst_i;
  logic                 wb_cyc_i;
  logic                 wb_stb_i;
  logic                 wb_we_i;
  logic [`GPIO_AW-1:0]  wb_adr_i;
  logic [3:0]           wb_sel_i;
  gpio_pkg::gpio_word_t wb_dat_i;
  gpio_pkg::gpio_word_t wb_dat_o;
  logic                 wb_ack_o;
  logic                 wb_err_o;
  logic                 wb_inta_o;
  gpio_pkg::gpio_word_t gpio_i;
  gpio_pkg::gpio_word_t gpio_o;
  gpio_pkg::gpio_word_t gpio_oe_o;

  integer seed;
  integer errors;
  integer checks;

  // Register model
  // m_pins holds the last value driven on gpio_i
  gpio_pkg::gpio_word_t m_out;
  gpio_pkg::gpio_word_t m_oe;
  gpio_pkg::gpio_word_t m_inte;
  gpio_pkg::gpio_word_t m_ptrig;
  gpio_pkg::gpio_word_t m_ints;
  gpio_pkg::gpio_word_t m_pins;
  logic                 m_ie;

  gpio_top u_dut (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_sel_i  (wb_sel_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .wb_err_o  (wb_err_o),
    .wb_inta_o (wb_inta_o),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o)
  );

  // 100 ns clock
  initial begin
    wb_clk_i = 1'b0;
    forever #50 wb_clk_i = ~wb_clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Model helpers
  ////////////////////////////////////////////////////////////

  // Bit by bit merge of the selected byte lanes
  function automatic gpio_pkg::gpio_word_t merge_lanes(input gpio_pkg::gpio_word_t old,
                                                       input gpio_pkg::gpio_word_t dat,
                                                       input logic [3:0] sel);
    gpio_pkg::gpio_word_t res;
    res = old;
    for (int b = 0; b < `GPIO_IOS; b++) begin
      if (sel[b / 8]) begin
        res[b] = dat[b];
      end
    end
    return res;
  endfunction

  function automatic gpio_pkg::gpio_word_t to_word(input logic b);
    return {{(`GPIO_IOS-1){1'b0}}, b};
  endfunction

  // Expected read value of one register
  function automatic gpio_pkg::gpio_word_t model_value(input logic [2:0] ofs);
    case (ofs)
      `GPIO_OFS_IN:    return m_pins;
      `GPIO_OFS_OUT:   return m_out;
      `GPIO_OFS_OE:    return m_oe;
      `GPIO_OFS_INTE:  return m_inte;
      `GPIO_OFS_PTRIG: return m_ptrig;
      `GPIO_OFS_CTRL:  return to_word(m_ie);
      `GPIO_OFS_INTS:  return m_ints;
      default:         return '0;
    endcase
  endfunction

  task automatic check_value(input string name, input gpio_pkg::gpio_word_t exp,
                             input gpio_pkg::gpio_word_t act);
    checks = checks + 1;
    if (act !== exp) begin
      errors = errors + 1;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  // Leaves the caller 5 ns after a rising edge
  task automatic idle(input integer n);
    for (int i = 0; i < n; i++) begin
      @(posedge wb_clk_i);
    end
    #5;
  endtask

  ////////////////////////////////////////////////////////////
  // Wishbone master
  ////////////////////////////////////////////////////////////

  // One classic cycle held until ack or err
  task automatic bus_cycle(input logic we, input logic [2:0] ofs, input logic [3:0] sel,
                           input gpio_pkg::gpio_word_t dat,
                           output gpio_pkg::gpio_word_t rdat, output logic err);
    logic done;
    done = 1'b0;
    err  = 1'b0;
    rdat = '0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = {ofs, 2'b00};
    wb_sel_i = sel;
    wb_dat_i = dat;
    for (int i = 0; i < 20 && !done; i++) begin
      @(posedge wb_clk_i);
      #5;
      if (wb_ack_o || wb_err_o) begin
        done = 1'b1;
        err  = wb_err_o;
        rdat = wb_dat_o;
      end
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (!done) begin
      errors = errors + 1;
      $display("Timeout: no ack or err within 20 cycles for offset %0d", ofs);
    end
  endtask

  task automatic wb_write(input logic [2:0] ofs, input logic [3:0] sel,
                          input gpio_pkg::gpio_word_t dat, output logic err);
    gpio_pkg::gpio_word_t unused;
    bus_cycle(1'b1, ofs, sel, dat, unused, err);
  endtask

  task automatic wb_read(input logic [2:0] ofs, output gpio_pkg::gpio_word_t dat,
                         output logic err);
    bus_cycle(1'b0, ofs, 4'hf, '0, dat, err);
  endtask

  ////////////////////////////////////////////////////////////
  // Model-aware accesses
  ////////////////////////////////////////////////////////////

  task automatic write_reg(input logic [2:0] ofs, input logic [3:0] sel,
                           input gpio_pkg::gpio_word_t dat);
    logic err;
    wb_write(ofs, sel, dat, err);
    check_value($sformatf("write err at offset %0d", ofs), '0, to_word(err));
    case (ofs)
      `GPIO_OFS_OUT:   m_out   = merge_lanes(m_out, dat, sel);
      `GPIO_OFS_OE:    m_oe    = merge_lanes(m_oe, dat, sel);
      `GPIO_OFS_INTE:  m_inte  = merge_lanes(m_inte, dat, sel);
      `GPIO_OFS_PTRIG: m_ptrig = merge_lanes(m_ptrig, dat, sel);
      `GPIO_OFS_CTRL:  m_ie    = sel[0] ? dat[0] : m_ie;
      // Write one to clear on the enabled lanes
      `GPIO_OFS_INTS:  m_ints  = m_ints & ~merge_lanes('0, dat, sel);
      default: ;
    endcase
  endtask

  task automatic read_check(input string tag, input logic [2:0] ofs);
    gpio_pkg::gpio_word_t dat;
    logic                 err;
    wb_read(ofs, dat, err);
    check_value($sformatf("%s read err at offset %0d", tag, ofs), '0, to_word(err));
    check_value($sformatf("%s offset %0d", tag, ofs), model_value(ofs), dat);
  endtask

  task automatic check_all(input string tag);
    for (int r = 0; r < 7; r++) begin
      read_check(tag, 3'(r));
    end
  endtask

  // Pin outputs and interrupt line
  task automatic check_pins(input string tag);
    check_value({tag, " gpio_o"}, m_out, gpio_o);
    check_value({tag, " gpio_oe_o"}, m_oe, gpio_oe_o);
    check_value({tag, " wb_inta_o"}, to_word(m_ie && (m_ints != '0)), to_word(wb_inta_o));
  endtask

  // New pin value and its status bits, then time to settle
  task automatic drive_pins(input gpio_pkg::gpio_word_t val);
    for (int p = 0; p < `GPIO_IOS; p++) begin
      if (m_inte[p] && (m_pins[p] != val[p])) begin
        // The selected edge ends at the PTRIG level
        if (val[p] == m_ptrig[p]) begin
          m_ints[p] = 1'b1;
        end
      end
    end
    m_pins = val;
    gpio_i = val;
    idle(8);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]          r;
    logic [2:0]           ofs;
    logic                 err;
    gpio_pkg::gpio_word_t dat;
    seed     = 2775;
    errors   = 0;
    checks   = 0;
    m_out    = '0;
    m_oe     = '0;
    m_inte   = '0;
    m_ptrig  = '0;
    m_ints   = '0;
    m_pins   = '0;
    m_ie     = 1'b0;
    wb_rst_i = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_sel_i = '0;
    wb_dat_i = '0;
    gpio_i   = '0;
    repeat (4) @(posedge wb_clk_i);
    #5;
    wb_rst_i = 1'b0;
    idle(1);

    // Reset values
    check_all("reset");
    check_pins("reset");

    // Byte-lane writes to OUT, OE, INTE, PTRIG and CTRL
    for (int n = 0; n < 40; n++) begin
      r   = $random(seed);
      dat = $random(seed);
      ofs = 3'((r[7:0] % 8'd5) + 8'd1);
      write_reg(ofs, r[11:8], dat);
      read_check("lanes", ofs);
      check_pins("lanes");
    end
    check_all("lanes final");

    // Input path
    // Stray edges are tracked by the model
    for (int n = 0; n < 5; n++) begin
      drive_pins($random(seed));
      read_check("input", `GPIO_OFS_IN);
      check_pins("input");
    end

    // Interrupts on the selected edges
    write_reg(`GPIO_OFS_INTE, 4'hf, $random(seed));
    write_reg(`GPIO_OFS_PTRIG, 4'hf, $random(seed));
    write_reg(`GPIO_OFS_CTRL, 4'hf, $random(seed));
    for (int n = 0; n < 6; n++) begin
      drive_pins($random(seed));
      read_check("irq", `GPIO_OFS_INTS);
      check_pins("irq");
    end

    // Status clear with the global enable on
    write_reg(`GPIO_OFS_CTRL, 4'hf, 32'h1);
    for (int n = 0; n < 6; n++) begin
      r   = $random(seed);
      dat = $random(seed);
      write_reg(`GPIO_OFS_INTS, r[3:0], dat);
      idle(2);
      read_check("clear", `GPIO_OFS_INTS);
      check_pins("clear");
    end

    // Bus errors leave every register alone
    wb_read(`GPIO_OFS_NONE, dat, err);
    check_value("err on read of offset 7", to_word(1'b1), to_word(err));
    wb_write(`GPIO_OFS_NONE, 4'hf, $random(seed), err);
    check_value("err on write of offset 7", to_word(1'b1), to_word(err));
    wb_write(`GPIO_OFS_IN, 4'hf, $random(seed), err);
    check_value("err on write of RGPIO_IN", to_word(1'b1), to_word(err));
    idle(2);
    check_all("after errors");
    check_pins("after errors");

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
gpio_pkg.sv
gpio_wb_ctrl.sv
gpio_in_sync.sv
gpio_out_regs.sv
gpio_int_unit.sv
gpio_top.sv
gpio_sva.sv
gpio_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the GPIO testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module gpio_tb \
  --Mdir obj_dir -o gpio_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/gpio_sim 2>&1)"
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
